// ==== verilog/tm1638_settings.svh ====
// TM1638 display driver constants for bit timing and frame size
`ifndef TM1638_SETTINGS_SVH
`define TM1638_SETTINGS_SVH

// clock cycles per half period of the TM1638 clock
`define TM1638_HALF_BIT 4

// digits and LEDs interleaved, digit at even address
`define TM1638_DISPLAY_BYTES 16

// address command followed by all display bytes
`define TM1638_BATCH_BYTES 17

`endif

// ==== verilog/tm1638_pkg.sv ====
// TM1638 display driver shared types for transfers, host writes and command bytes
`include "tm1638_settings.svh"

package tm1638_pkg;

	// one transfer handed to the serial engine
	// payload byte BATCH-1 goes out first, count 1 is a lone command
	typedef struct packed {
		logic [4:0]                               count;   // bytes to send
		logic [`TM1638_BATCH_BYTES-1:0][7:0]      payload; // first byte on top
	} tm1638_xfer_t;

	// one host write into the display memory
	typedef struct packed {
		logic [3:0] addr; // even = digit, odd = LED
		logic [7:0] data; // segment or LED byte
	} disp_write_t;

	// command bytes used by the refresh engine
	typedef enum logic [7:0] {
		CMD_AUTO_INC = 8'h40, // data command, auto increment
		CMD_ADDR0    = 8'hC0, // address command, start at 0
		CMD_ACTIVATE = 8'h88  // display on, lowest brightness
	} cmd_e;

endpackage

// ==== verilog/display_ram.sv ====
// display memory: sixteen bytes written by the host, read with one cycle latency
`timescale 1ns/1ps
`include "tm1638_settings.svh"

module display_ram (
	input  logic                    i_clk,
	input  logic                    i_reset,
	input  logic                    i_wr_valid,
	input  tm1638_pkg::disp_write_t i_wr,
	input  logic [3:0]              i_rd_addr,
	output logic [7:0]              o_rd_data
);

	logic [7:0] mem [`TM1638_DISPLAY_BYTES]; // digit/LED image

	// host side, a write is taken on every valid edge
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			for (int i = 0; i < `TM1638_DISPLAY_BYTES; i++) begin
				mem[i] <= 8'h00; // blank display after reset
			end
		end else if (i_wr_valid) begin
			mem[i_wr.addr] <= i_wr.data;
		end
	end

	// registered read, a same-cycle write shows up one read later
	always_ff @(posedge i_clk) begin
		o_rd_data <= mem[i_rd_addr];
	end

endmodule

// ==== verilog/tm1638_serial.sv ====
// TM1638 serial engine framing a command or byte batch under strobe on the clock and data pins
`timescale 1ns/1ps
`include "tm1638_settings.svh"

module tm1638_serial (
	input  logic                     i_clk,
	input  logic                     i_reset,
	input  logic                     i_xfer_valid,
	input  tm1638_pkg::tm1638_xfer_t i_xfer,
	output logic                     o_xfer_ready,
	output logic                     o_tm1638_stb,
	output logic                     o_tm1638_clk,
	output logic                     o_tm1638_dio
);

	localparam int HALF_BIT = `TM1638_HALF_BIT;
	localparam int TOP      = `TM1638_BATCH_BYTES - 1;
	localparam int DIV_W    = (HALF_BIT > 1) ? $clog2(HALF_BIT) : 1;

	typedef enum logic [2:0] {
		ST_IDLE, // strobe high and ready
		ST_LEAD, // strobe low with clk still high
		ST_LOW,  // clk low while data sets up
		ST_HIGH, // clk high with data held
		ST_STOP, // last bit done with clk high
		ST_GAP   // strobe high before next transfer
	} state_e;

	state_e           state;
	logic [DIV_W-1:0] div_cnt;    // half-bit divider
	logic             half_done;
	logic [2:0]       bit_cnt;    // bit within current byte
	logic [2:0]       next_bit;
	logic [4:0]       bytes_left; // including current byte
	logic [TOP:0][7:0] shift_q;   // current byte on top
	logic             accept;

	assign o_xfer_ready = (state == ST_IDLE) && !i_reset; // low in the reset cycle
	assign accept       = i_xfer_valid && o_xfer_ready;
	assign half_done    = (div_cnt == DIV_W'(HALF_BIT - 1));
	assign next_bit     = bit_cnt + 3'd1;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state        <= ST_IDLE;
			div_cnt      <= '0;
			bit_cnt      <= '0;
			bytes_left   <= '0;
			o_tm1638_stb <= 1'b1;
			o_tm1638_clk <= 1'b1;
			o_tm1638_dio <= 1'b1;
		end else begin
			if (state == ST_IDLE || half_done) begin
				div_cnt <= '0; // every phase starts from zero
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end

			case (state)
			ST_IDLE: begin
				if (accept) begin
					shift_q      <= i_xfer.payload;
					bytes_left   <= i_xfer.count;
					bit_cnt      <= '0;
					o_tm1638_stb <= 1'b0; // low one cycle after acceptance
					state        <= ST_LEAD;
				end
			end

			ST_LEAD: begin
				if (half_done) begin
					o_tm1638_clk <= 1'b0;
					o_tm1638_dio <= shift_q[TOP][0]; // lsb first
					state        <= ST_LOW;
				end
			end

			ST_LOW: begin
				if (half_done) begin
					o_tm1638_clk <= 1'b1; // board samples on this rise
					state        <= ST_HIGH;
				end
			end

			ST_HIGH: begin
				if (half_done) begin
					if (bit_cnt != 3'd7) begin
						bit_cnt      <= next_bit;
						o_tm1638_clk <= 1'b0;
						o_tm1638_dio <= shift_q[TOP][next_bit];
						state        <= ST_LOW;
					end else if (bytes_left > 5'd1) begin
						// move on to the next byte of the batch
						shift_q      <= {shift_q[TOP-1:0], 8'h00};
						bytes_left   <= bytes_left - 5'd1;
						bit_cnt      <= '0;
						o_tm1638_clk <= 1'b0;
						o_tm1638_dio <= shift_q[TOP-1][0];
						state        <= ST_LOW;
					end else begin
						state <= ST_STOP; // clk stays high
					end
				end
			end

			ST_STOP: begin
				if (half_done) begin
					o_tm1638_stb <= 1'b1;
					o_tm1638_dio <= 1'b1; // idle level
					state        <= ST_GAP;
				end
			end

			ST_GAP: begin
				if (half_done) begin
					state <= ST_IDLE;
				end
			end

			default: begin
				state <= ST_IDLE;
			end
			endcase
		end
	end

endmodule

// ==== verilog/tm1638_refresh.sv ====
// TM1638 refresh engine: power-on command sequence, then endless frame batches from memory
`timescale 1ns/1ps
`include "tm1638_settings.svh"

module tm1638_refresh (
	input  logic                     i_clk,
	input  logic                     i_reset,
	input  logic                     i_en,
	output logic [3:0]               o_rd_addr,
	input  logic [7:0]               i_rd_data,
	output logic                     o_xfer_valid,
	output tm1638_pkg::tm1638_xfer_t o_xfer,
	input  logic                     i_xfer_ready,
	output logic                     o_idle_frame
);

	localparam int         BATCH     = `TM1638_BATCH_BYTES;
	localparam logic [3:0] LAST_ADDR = 4'(`TM1638_DISPLAY_BYTES - 1);

	typedef enum logic [2:0] {
		S_INIT_AUTO,  // data command
		S_INIT_CLEAR, // blank image
		S_INIT_ACT,   // display on
		S_IDLE,
		S_FETCH,
		S_WAIT_MEM,
		S_FILL,
		S_SEND
	} state_e;

	state_e     state;
	logic       xfer_take; // serial engine takes the transfer this edge
	logic       offer;     // allowed to raise valid now
	logic [4:0] fill_pos;  // payload slot of the fetched byte

	assign xfer_take    = o_xfer_valid && i_xfer_ready;
	assign offer        = i_en && !o_xfer_valid;
	assign o_idle_frame = (state == S_IDLE);
	assign fill_pos     = 5'(BATCH - 2) - {1'b0, o_rd_addr}; // address + 1 behind C0

	// command byte on top, remaining payload blank
	function automatic tm1638_pkg::tm1638_xfer_t batch_head(
		input tm1638_pkg::cmd_e cmd,
		input logic [4:0]       count
	);
		tm1638_pkg::tm1638_xfer_t x;
		x.count              = count;
		x.payload            = '0;
		x.payload[BATCH - 1] = cmd;
		return x;
	endfunction

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state        <= S_INIT_AUTO;
			o_xfer_valid <= 1'b0;
			o_rd_addr    <= '0;
		end else begin
			if (xfer_take) begin
				o_xfer_valid <= 1'b0;
			end

			case (state)
			S_INIT_AUTO: begin
				if (xfer_take) begin
					state <= S_INIT_CLEAR;
				end else if (offer) begin
					o_xfer       <= batch_head(tm1638_pkg::CMD_AUTO_INC, 5'd1);
					o_xfer_valid <= 1'b1;
				end
			end

			S_INIT_CLEAR: begin
				if (xfer_take) begin
					state <= S_INIT_ACT;
				end else if (offer) begin
					o_xfer       <= batch_head(tm1638_pkg::CMD_ADDR0, 5'(BATCH));
					o_xfer_valid <= 1'b1;
				end
			end

			S_INIT_ACT: begin
				if (xfer_take) begin
					state <= S_IDLE;
				end else if (offer) begin
					o_xfer       <= batch_head(tm1638_pkg::CMD_ACTIVATE, 5'd1);
					o_xfer_valid <= 1'b1;
				end
			end

			S_IDLE: begin
				// wait for strobe high so writes of the last batch are all in
				if (i_en && i_xfer_ready) begin
					o_rd_addr <= '0;
					o_xfer    <= batch_head(tm1638_pkg::CMD_ADDR0, 5'(BATCH));
					state     <= S_FETCH;
				end
			end

			S_FETCH: begin
				state <= S_WAIT_MEM; // address on the RAM port
			end

			S_WAIT_MEM: begin
				state <= S_FILL; // RAM read register loads
			end

			S_FILL: begin
				o_xfer.payload[fill_pos] <= i_rd_data;
				if (o_rd_addr == LAST_ADDR) begin
					state <= S_SEND;
				end else begin
					o_rd_addr <= o_rd_addr + 4'd1;
					state     <= S_FETCH;
				end
			end

			S_SEND: begin
				if (xfer_take) begin
					state <= S_IDLE;
				end else if (offer) begin
					o_xfer_valid <= 1'b1; // batch held until taken
				end
			end

			default: begin
				state <= S_INIT_AUTO;
			end
			endcase
		end
	end

endmodule

// ==== verilog/tm1638_display.sv ====
// TM1638 LED&KEY display top: host-written memory refreshed onto the board pins
`timescale 1ns/1ps

module tm1638_display (
	input  logic                    i_clk,
	input  logic                    i_reset,
	input  logic                    i_en,
	input  logic                    i_wr_valid,
	input  tm1638_pkg::disp_write_t i_wr,
	output logic                    o_tm1638_stb,
	output logic                    o_tm1638_clk,
	output logic                    o_tm1638_dio,
	output logic                    o_idle
);

	logic [3:0]               rd_addr;
	logic [7:0]               rd_data;
	logic                     xfer_valid;
	logic                     xfer_ready;
	logic                     idle_frame;
	tm1638_pkg::tm1638_xfer_t xfer;

	// between frames and nothing on the wire
	assign o_idle = idle_frame && xfer_ready;

	display_ram u_ram (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_wr_valid (i_wr_valid),
		.i_wr       (i_wr),
		.i_rd_addr  (rd_addr),
		.o_rd_data  (rd_data)
	);

	tm1638_refresh u_refresh (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_en         (i_en),
		.o_rd_addr    (rd_addr),
		.i_rd_data    (rd_data),
		.o_xfer_valid (xfer_valid),
		.o_xfer       (xfer),
		.i_xfer_ready (xfer_ready),
		.o_idle_frame (idle_frame)
	);

	tm1638_serial u_serial (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_xfer_valid (xfer_valid),
		.i_xfer       (xfer),
		.o_xfer_ready (xfer_ready),
		.o_tm1638_stb (o_tm1638_stb),
		.o_tm1638_clk (o_tm1638_clk),
		.o_tm1638_dio (o_tm1638_dio)
	);

endmodule

// ==== test/tb_clock.sv ====
// testbench clock and power-on reset generator
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 4
) (
	output logic o_clk,
	output logic o_reset
);

	initial begin
		o_clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2) o_clk = ~o_clk;
		end
	end

	initial begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clk);
		@(negedge o_clk); // released between edges
		o_reset = 1'b0;
	end

endmodule

// ==== test/tm1638_display_assert.sv ====
// TM1638 pin checker that rebuilds transfers from the pins and checks protocol and frame content
`timescale 1ns/1ps
`include "tm1638_settings.svh"

module tm1638_display_assert (
	input logic                    i_clk,
	input logic                    i_reset,
	input logic                    i_en,
	input logic                    i_wr_valid,
	input tm1638_pkg::disp_write_t i_wr,
	input logic                    i_stb,
	input logic                    i_sclk,
	input logic                    i_dio,
	input logic                    i_idle
);

	localparam int         TOP          = `TM1638_BATCH_BYTES - 1;
	localparam logic [7:0] EXP_AUTO_INC = 8'h40;
	localparam logic [7:0] EXP_ADDR0    = 8'hC0;
	localparam logic [7:0] EXP_ACTIVATE = 8'h88;

	int fail_count = 0; // read by the testbench

	logic stb_q;
	logic sclk_q;
	logic stb_rise;
	logic [2:0] rx_bit;                                 // bit within byte on the wire
	int xfer_idx;                                       // transfers seen since reset
	tm1638_pkg::tm1638_xfer_t rx;                       // bytes rebuilt from dio
	tm1638_pkg::tm1638_xfer_t exp_x;
	logic [`TM1638_DISPLAY_BYTES-1:0][7:0] pending;    // writes so far
	logic [`TM1638_DISPLAY_BYTES-1:0][7:0] committed;  // image due in the next frame

	assign stb_rise = i_stb && !stb_q;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			stb_q     <= 1'b1;
			sclk_q    <= 1'b1;
			rx_bit    <= '0;
			rx        <= '0;
			xfer_idx  <= 0;
			pending   <= '0;
			committed <= '0;
		end else begin
			stb_q  <= i_stb;
			sclk_q <= i_sclk;
			if (!i_stb && i_sclk && !sclk_q) begin
				if (rx.count < 5'(`TM1638_BATCH_BYTES)) begin
					rx.payload[5'(TOP) - rx.count][rx_bit] <= i_dio; // lsb first
				end
				if (rx_bit == 3'd7) begin
					rx.count <= rx.count + 5'd1;
				end
				rx_bit <= rx_bit + 3'd1;
			end
			if (i_wr_valid && !i_stb) begin
				pending[i_wr.addr] <= i_wr.data;
			end
			if (stb_rise) begin
				committed <= pending; // fetched by the following frame
				rx        <= '0;
				rx_bit    <= '0;
				xfer_idx  <= xfer_idx + 1;
			end
		end
	end

	// init sequence first and then C0 with the image in address order
	always_comb begin
		exp_x.count        = 5'(`TM1638_BATCH_BYTES);
		exp_x.payload      = '0;
		exp_x.payload[TOP] = EXP_ADDR0;
		if (xfer_idx == 0) begin
			exp_x.count        = 5'd1;
			exp_x.payload[TOP] = EXP_AUTO_INC;
		end else if (xfer_idx == 2) begin
			exp_x.count        = 5'd1;
			exp_x.payload[TOP] = EXP_ACTIVATE;
		end else if (xfer_idx > 2) begin
			for (int a = 0; a < `TM1638_DISPLAY_BYTES; a++) begin
				exp_x.payload[5'(TOP - 1 - a)] = committed[4'(a)];
			end
		end
	end

	a_reset_state: assert property (@(posedge i_clk)
		$fell(i_reset) |-> (i_stb && i_sclk && i_dio && !i_idle))
	else begin
		$error("FAILED at %0t: after reset stb %b clk %b dio %b idle %b", $time,
			$sampled(i_stb), $sampled(i_sclk), $sampled(i_dio), $sampled(i_idle));
		fail_count++;
	end

	a_dio_in_low: assert property (@(posedge i_clk) disable iff (i_reset)
		$changed(i_dio) |-> (!i_sclk || i_stb))
	else begin
		$error("FAILED at %0t: dio moved while clk was high inside a frame", $time);
		fail_count++;
	end

	a_clk_idle: assert property (@(posedge i_clk) disable iff (i_reset)
		i_stb |-> i_sclk)
	else begin
		$error("FAILED at %0t: clk low while strobe high", $time);
		fail_count++;
	end

	a_whole_bytes: assert property (@(posedge i_clk) disable iff (i_reset)
		stb_rise |-> (rx_bit == 3'd0 && rx.count != 5'd0))
	else begin
		$error("FAILED at %0t: frame ended after %0d bytes and %0d bits", $time,
			$sampled(rx.count), $sampled(rx_bit));
		fail_count++;
	end

	a_content: assert property (@(posedge i_clk) disable iff (i_reset)
		stb_rise |-> (rx == exp_x))
	else begin
		$error("FAILED at %0t: transfer %0d got %0d bytes from %h, expected %0d from %h",
			$time, $sampled(xfer_idx), $sampled(rx.count), $sampled(rx.payload[TOP]),
			$sampled(exp_x.count), $sampled(exp_x.payload[TOP]));
		fail_count++;
	end

	a_pause: assert property (@(posedge i_clk) disable iff (i_reset)
		$fell(i_stb) |-> $past(i_en, 2))
	else begin
		$error("FAILED at %0t: new transfer started with refresh disabled", $time);
		fail_count++;
	end

	a_idle_busy: assert property (@(posedge i_clk) disable iff (i_reset)
		!i_stb |-> !i_idle)
	else begin
		$error("FAILED at %0t: idle high while strobe low", $time);
		fail_count++;
	end

	// refresh engine waits between frames once the activate command is out
	a_idle_gap: assert property (@(posedge i_clk) disable iff (i_reset)
		(stb_rise && xfer_idx >= 2) |-> ##(`TM1638_HALF_BIT) i_idle)
	else begin
		$error("FAILED at %0t: idle low after the strobe gap of transfer %0d", $time,
			xfer_idx);
		fail_count++;
	end

	a_idle_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_idle && !i_en) |=> i_idle)
	else begin
		$error("FAILED at %0t: idle dropped with refresh disabled", $time);
		fail_count++;
	end

endmodule

// ==== test/tm1638_display_tb.sv ====
// TM1638 display testbench: reset, init, random frame content, pause and resume
`timescale 1ns/1ps
`include "tm1638_settings.svh"

module tm1638_display_tb;

	localparam int BYTE_CYC      = 8 * 2 * `TM1638_HALF_BIT;
	localparam int FRAME_CYC     = `TM1638_BATCH_BYTES * BYTE_CYC + 4 * `TM1638_HALF_BIT
		+ 3 * `TM1638_DISPLAY_BYTES + 4;
	localparam int INIT_CYC      = 2 * (BYTE_CYC + 4 * `TM1638_HALF_BIT) + FRAME_CYC + 8;
	localparam int ROUNDS        = 12; // two frames per round
	localparam int PAUSE_FRAMES  = 4;
	localparam int RESUME_FRAMES = 2;
	localparam int TIMEOUT_CYC   = INIT_CYC + 30 * BYTE_CYC
		+ (2 * ROUNDS + 1 + PAUSE_FRAMES + RESUME_FRAMES) * FRAME_CYC;

	logic clk;
	logic reset;
	logic en;
	logic wr_valid;
	tm1638_pkg::disp_write_t wr;
	logic stb;
	logic sclk;
	logic dio;
	logic idle;
	int cycles = 0;
	int tests_run;
	int tests_bad;
	int fails_before;

	tb_clock u_clock (
		.o_clk   (clk),
		.o_reset (reset)
	);

	tm1638_display uut (
		.i_clk        (clk),
		.i_reset      (reset),
		.i_en         (en),
		.i_wr_valid   (wr_valid),
		.i_wr         (wr),
		.o_tm1638_stb (stb),
		.o_tm1638_clk (sclk),
		.o_tm1638_dio (dio),
		.o_idle       (idle)
	);

	bind tm1638_display tm1638_display_assert u_assert (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_en       (i_en),
		.i_wr_valid (i_wr_valid),
		.i_wr       (i_wr),
		.i_stb      (o_tm1638_stb),
		.i_sclk     (o_tm1638_clk),
		.i_dio      (o_tm1638_dio),
		.i_idle     (o_idle)
	);

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYC) begin
			$display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYC);
			$display("TEST FAILED");
			$finish;
		end
	end

	// end of a transfer, plus time for the checker to fire
	task automatic wait_strobe_rise();
		@(posedge stb);
		repeat (2) @(negedge clk);
	endtask

	task automatic wait_strobe_fall();
		@(negedge stb);
		@(negedge clk);
	endtask

	// one byte per cycle, digits and LEDs alike
	task automatic load_random_image();
		for (int a = 0; a < `TM1638_DISPLAY_BYTES; a++) begin
			wr_valid = 1'b1;
			wr.addr  = 4'(a);
			wr.data  = 8'($urandom());
			@(negedge clk);
		end
		wr_valid = 1'b0;
	endtask

	task automatic report_test(input string name);
		int n;
		n = uut.u_assert.fail_count - fails_before;
		tests_run++;
		if (n == 0) begin
			$display("[%0t] %s: passed", $time, name);
		end else begin
			tests_bad++;
			$display("[%0t] %s: %0d assertion failures", $time, name, n);
		end
		fails_before = uut.u_assert.fail_count;
	endtask

	initial begin
		en           = 1'b1;
		wr_valid     = 1'b0;
		wr           = '0;
		tests_run    = 0;
		tests_bad    = 0;
		fails_before = 0;
		void'($urandom(32'hb92d_40c3));

		@(negedge reset);
		repeat (2) @(negedge clk);
		report_test("reset state");

		repeat (3) wait_strobe_rise(); // auto increment, clear, activate
		report_test("init sequence");

		for (int r = 0; r < ROUNDS; r++) begin
			wait_strobe_fall();
			load_random_image();
			wait_strobe_rise(); // image committed here
			wait_strobe_rise(); // first frame carrying it
		end
		report_test("frame content");

		wait_strobe_fall();
		en = 1'b0; // running batch still completes
		wait_strobe_rise();
		repeat (PAUSE_FRAMES * FRAME_CYC) @(negedge clk);
		report_test("pause");

		en = 1'b1;
		repeat (RESUME_FRAMES) wait_strobe_rise();
		report_test("resume");

		$display("summary: %0d tests, %0d with failures, %0d assertion failures",
			tests_run, tests_bad, uut.u_assert.fail_count);
		if (tests_bad == 0 && uut.u_assert.fail_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+verilog
verilog/tm1638_pkg.sv
verilog/display_ram.sv
verilog/tm1638_serial.sv
verilog/tm1638_refresh.sv
verilog/tm1638_display.sv
test/tb_clock.sv
test/tm1638_display_assert.sv
test/tm1638_display_tb.sv

// ==== Makefile ====
# Verilator build for the TM1638 display driver and its testbench
VERILATOR ?= verilator
TOP       ?= tm1638_display_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= TEST FAILED
PASS_MSG  ?= TEST OK
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a verdict"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
